// ==== filelist.f ====
src/cpu_isa_pkg.sv
src/cpu_pipe_pkg.sv
src/operand_forward.sv
src/alu.sv
src/ex_mem_pipe_reg.sv
src/data_memory.sv
src/mem_wb_pipe_reg.sv
src/cpu_backend.sv
tb/tb_cpu_backend.sv

// ==== Bender.yml ====
package:
  name: cpu_backend

sources:
  - src/cpu_isa_pkg.sv
  - src/cpu_pipe_pkg.sv
  - src/operand_forward.sv
  - src/alu.sv
  - src/ex_mem_pipe_reg.sv
  - src/data_memory.sv
  - src/mem_wb_pipe_reg.sv
  - src/cpu_backend.sv
  - target: test
    files:
      - tb/tb_cpu_backend.sv

// ==== tb/tb_cpu_backend.sv ====
`timescale 1ns/1ps

module tb_cpu_backend import cpu_isa_pkg::*, cpu_pipe_pkg::*; ();

  logic                  clk = 1'b0;
  logic                  arst_n;
  logic [DATA_W-1:0]     id_ex_pc_next;
  alu_op_e               alu_op;
  logic [REG_ADDR_W-1:0] rs_addr, rt_addr;
  logic [DATA_W-1:0]     rs_data, rt_data, imm;
  logic                  alu_src;
  logic [MEM_SIG_W-1:0]  id_ex_mem_signals;
  logic [WB_SIG_W-1:0]   id_ex_wb_signals;
  logic                  flush;
  logic                  wb_reg_write, wb_hlt;
  logic [REG_ADDR_W-1:0] wb_rd;
  logic [DATA_W-1:0]     wb_data;

  // What the write-back port should show for one instruction
  typedef struct packed {
    logic                  we;
    logic [REG_ADDR_W-1:0] rd;
    logic [DATA_W-1:0]     data;
    logic                  hlt;
  } wb_exp_t;

  wb_exp_t           exp_q[$];                     // Instructions in flight, oldest first
  logic [DATA_W-1:0] arch_regs [1 << REG_ADDR_W];  // Register values in program order
  logic [DATA_W-1:0] rf_regs [1 << REG_ADDR_W];    // Register file copy, written at WB
  logic [DATA_W-1:0] mem_model [DMEM_DEPTH];
  integer            seed = 32'hd8fd;
  int                checks = 0;
  int                errors = 0;
  int                test_errors = 0;
  logic              hlt_seen;                     // wb_hlt at the latest issue slot

  always #5 clk = ~clk;  // 10 ns period

  cpu_backend u_cpu_backend (.*);

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////
  function automatic logic [DATA_W-1:0] alu_model(input alu_op_e op,
                                                  input logic [DATA_W-1:0] a, b);
    int         sa;
    int         sb;
    int         s;
    logic [3:0] sh;
    sa = $signed(a);
    sb = $signed(b);
    sh = b[3:0];                                  // Shift amount is b bits 3:0
    case (op)
      ALU_ADD, ALU_SUB: begin
        s = (op == ALU_ADD) ? sa + sb : sa - sb;  // Exact result, then clamp
        if (s > 32767) return 16'h7FFF;
        if (s < -32768) return 16'h8000;
        return s[DATA_W-1:0];
      end
      ALU_XOR: return a ^ b;
      ALU_SLL: return a << sh;
      ALU_SRA: return $signed(a) >>> sh;
      ALU_ROR: return (a >> sh) | (a << (16 - sh));
      ALU_LLB: return {a[15:8], b[7:0]};
      default: return {b[7:0], a[7:0]};           // LHB
    endcase
  endfunction

  task automatic fail_value(input string msg);
    errors++;
    test_errors++;
    $display("** Error at %0t: %s", $time, msg);
  endtask

  task automatic check_wb(input wb_exp_t e);
    checks++;
    if (wb_reg_write !== e.we || wb_rd !== e.rd || wb_data !== e.data || wb_hlt !== e.hlt)
      fail_value($sformatf("wb we/rd/data/hlt %b/%0d/%h/%b, expected %b/%0d/%h/%b",
                           wb_reg_write, wb_rd, wb_data, wb_hlt, e.we, e.rd, e.data, e.hlt));
  endtask

  // Drives one instruction on the falling edge and predicts its write-back
  task automatic issue(input alu_op_e op, input logic [REG_ADDR_W-1:0] rd, rs, rt,
                       input logic src, input logic [DATA_W-1:0] imm_v,
                       input logic men, mwr, we, m2r, hlt, pcs, fl);
    logic [DATA_W-1:0] b;
    logic [DATA_W-1:0] res;
    logic [DATA_W-1:0] pc;
    wb_exp_t           e;
    wb_exp_t           done;
    @(negedge clk);
    if (exp_q.size() == 2) check_wb(exp_q[0]);  // Issued two edges ago
    hlt_seen = wb_hlt;
    pc  = $random(seed);
    b   = src ? imm_v : arch_regs[rt];
    res = alu_model(op, arch_regs[rs], b);
    alu_op            = op;
    rs_addr           = rs;
    rt_addr           = rt;
    rs_data           = rf_regs[rs];             // Stale copy, forwarding must fix it
    rt_data           = rf_regs[rt];
    imm               = imm_v;
    alu_src           = src;
    flush             = fl;
    id_ex_pc_next     = pc;
    id_ex_mem_signals = {arch_regs[rt], men, mwr};  // Store data is already resolved
    id_ex_wb_signals  = {rd, we, m2r, hlt, pcs};
    e = '0;                                      // A flushed slot retires as all zeros
    if (!fl) begin
      e.we   = we;
      e.rd   = rd;
      e.hlt  = hlt;
      e.data = pcs ? pc : m2r ? mem_model[res[8:1]] : res;
      if (men && mwr) mem_model[res[8:1]] = arch_regs[rt];
      if (we && rd != 0) arch_regs[rd] = e.data;  // r0 stays hardwired
    end
    exp_q.push_back(e);
    if (exp_q.size() == 3) begin
      done = exp_q.pop_front();                  // Register file write lands now
      if (done.we && done.rd != 0) rf_regs[done.rd] = done.data;
    end
  endtask

  task automatic nop();
    issue(ALU_ADD, 0, 0, 0, 1'b0, 16'h0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic alu_rr(input alu_op_e op, input logic [REG_ADDR_W-1:0] rd, rs, rt);
    issue(op, rd, rs, rt, 1'b0, 16'h0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic alu_ri(input alu_op_e op, input logic [REG_ADDR_W-1:0] rd, rs,
                        input logic [DATA_W-1:0] v);
    issue(op, rd, rs, 0, 1'b1, v, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic mem_store(input logic [REG_ADDR_W-1:0] rs, rt, input logic [DATA_W-1:0] off);
    issue(ALU_ADD, 0, rs, rt, 1'b1, off, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic mem_load(input logic [REG_ADDR_W-1:0] rd, rs, input logic [DATA_W-1:0] off);
    issue(ALU_ADD, rd, rs, 0, 1'b1, off, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic end_test(input string name);
    nop();
    nop();  // The second bubble compares the last real instruction
    $display("Test %s finished with %0d errors", name, test_errors);
    test_errors = 0;
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////
  task automatic test_reset();
    int cyc;
    for (cyc = 0; cyc < 8; cyc++) begin
      @(negedge clk);
      checks++;
      if (wb_reg_write !== 1'b0 || wb_hlt !== 1'b0 || wb_data !== '0)
        fail_value("write-back port not idle in reset");
    end
    arst_n = 1'b1;  // Released on a falling edge
    end_test("reset");
  endtask

  task automatic test_alu();
    int n;
    int i;
    for (n = 0; n < 4; n++) begin
      alu_ri(ALU_ADD, 3, 0, $random(seed));
      alu_ri(ALU_ADD, 6, 0, $random(seed));
      for (i = 0; i < 8; i++) begin
        alu_rr(alu_op_e'(i), 4, 3, 6);
        alu_ri(alu_op_e'(i), 5, 3, $random(seed));
      end
    end
    // Operands picked to overflow in both directions
    alu_ri(ALU_ADD, 3, 0, 16'h7000);
    alu_ri(ALU_ADD, 6, 0, 16'h8800);
    alu_ri(ALU_ADD, 4, 3, 16'h7000);
    alu_ri(ALU_SUB, 4, 3, 16'h9000);
    alu_rr(ALU_ADD, 5, 6, 6);
    alu_ri(ALU_SUB, 5, 6, 16'h7000);
    end_test("alu_ops");
  endtask

  task automatic test_mem();
    int                n;
    logic [DATA_W-1:0] addr;
    for (n = 0; n < 4; n++) begin
      addr = $random(seed);
      alu_ri(ALU_ADD, 7, 0, $random(seed));  // Fresh store data in r7
      mem_store(0, 7, addr);
      mem_load(8, 0, addr);                  // Reads the word stored one edge earlier
    end
    end_test("store_load");
  endtask

  task automatic test_forward();
    alu_ri(ALU_ADD, 9, 0, $random(seed));
    alu_rr(ALU_ADD, 10, 9, 11);   // rs from EX/MEM
    alu_rr(ALU_XOR, 12, 11, 9);   // rt from MEM/WB
    alu_rr(ALU_SUB, 13, 10, 12);  // Both paths at once
    alu_ri(ALU_ADD, 9, 0, $random(seed));
    alu_ri(ALU_XOR, 9, 0, $random(seed));
    alu_rr(ALU_ADD, 14, 9, 9);    // EX/MEM must win over MEM/WB
    alu_ri(ALU_ADD, 0, 0, 16'h1234);
    alu_rr(ALU_ADD, 15, 0, 0);    // r0 comes from rs_data
    alu_ri(ALU_ADD, 0, 0, 16'h4321);
    nop();
    alu_rr(ALU_XOR, 15, 0, 9);
    end_test("forwarding");
  endtask

  task automatic test_flush();
    alu_ri(ALU_ADD, 7, 0, $random(seed));
    mem_store(0, 7, 16'h0080);
    alu_ri(ALU_ADD, 7, 0, $random(seed));
    // Store plus write to r11, squashed in EX/MEM
    issue(ALU_ADD, 11, 0, 7, 1'b1, 16'h0080, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1);
    mem_load(8, 0, 16'h0080);
    alu_rr(ALU_ADD, 12, 11, 0);  // r11 keeps its old value
    end_test("flush");
  endtask

  task automatic test_pcs_halt();
    int cnt;
    issue(ALU_ADD, 13, 0, 0, 1'b1, 16'h0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0);
    issue(ALU_ADD, 0, 0, 0, 1'b0, 16'h0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
    for (cnt = 1; cnt <= 6; cnt++) begin
      nop();
      if (hlt_seen) break;
    end
    checks++;
    if (!hlt_seen) begin
      errors++;
      test_errors++;
      $display("Timeout: wb_hlt did not rise within 6 cycles of the halt instruction");
    end else if (cnt != 2) begin
      fail_value($sformatf("wb_hlt rose %0d edges after the halt, expected 2", cnt));
    end
    end_test("pcs_halt");
  endtask

  initial begin
    arst_n            = 1'b0;
    id_ex_pc_next     = '0;
    alu_op            = ALU_ADD;
    rs_addr           = '0;
    rt_addr           = '0;
    rs_data           = '0;
    rt_data           = '0;
    imm               = '0;
    alu_src           = 1'b0;
    id_ex_mem_signals = '0;
    id_ex_wb_signals  = '0;
    flush             = 1'b0;
    for (int r = 0; r < (1 << REG_ADDR_W); r++) begin
      arch_regs[r] = (r == 0) ? 16'h0 : 16'($random(seed));
      rf_regs[r]   = arch_regs[r];
    end
    test_reset();
    test_alu();
    test_mem();
    test_forward();
    test_flush();
    test_pcs_halt();
    $display("Checks run %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== src/cpu_backend.sv ====
`timescale 1ns/1ps

module cpu_backend import cpu_isa_pkg::*, cpu_pipe_pkg::*; (
  input  logic                  clk,
  input  logic                  arst_n,
  // ID/EX side, one instruction per cycle
  input  logic [DATA_W-1:0]     id_ex_pc_next,
  input  alu_op_e               alu_op,
  input  logic [REG_ADDR_W-1:0] rs_addr,
  input  logic [DATA_W-1:0]     rs_data,
  input  logic [REG_ADDR_W-1:0] rt_addr,
  input  logic [DATA_W-1:0]     rt_data,
  input  logic [DATA_W-1:0]     imm,
  input  logic                  alu_src,            // 1 selects imm as operand b
  input  logic [MEM_SIG_W-1:0]  id_ex_mem_signals,
  input  logic [WB_SIG_W-1:0]   id_ex_wb_signals,
  input  logic                  flush,
  // Register file write port and halt
  output logic                  wb_reg_write,
  output logic [REG_ADDR_W-1:0] wb_rd,
  output logic [DATA_W-1:0]     wb_data,
  output logic                  wb_hlt
);

  logic [DATA_W-1:0]    operand_a, operand_b, alu_out;
  logic [DATA_W-1:0]    ex_mem_pc_next, ex_mem_alu_out;
  logic [MEM_SIG_W-1:0] ex_mem_mem_signals;
  logic [WB_SIG_W-1:0]  ex_mem_wb_signals;
  logic [DATA_W-1:0]    mem_rdata;

  //////////////////////////////////////////////////
  // Execute
  //////////////////////////////////////////////////
  operand_forward u_operand_forward (
    .rs_addr, .rt_addr, .rs_data, .rt_data, .imm, .alu_src, .ex_mem_alu_out,
    .ex_mem_rd        (ex_mem_wb_signals[WB_RD_LSB +: REG_ADDR_W]),
    .ex_mem_reg_write (ex_mem_wb_signals[WB_REG_WRITE_BIT]),
    .wb_rd, .wb_reg_write, .wb_data, .operand_a, .operand_b
  );

  alu u_alu (.clk, .arst_n, .alu_op, .operand_a, .operand_b, .alu_out);

  ex_mem_pipe_reg u_ex_mem_pipe_reg (
    .clk, .arst_n, .flush, .id_ex_pc_next, .alu_out, .id_ex_mem_signals, .id_ex_wb_signals,
    .ex_mem_pc_next, .ex_mem_alu_out, .ex_mem_mem_signals, .ex_mem_wb_signals
  );

  // Memory, indexed by the word part of the ALU result
  data_memory u_data_memory (
    .clk,
    .addr  (ex_mem_alu_out[DMEM_ADDR_LSB +: DMEM_ADDR_W]),
    .wdata (ex_mem_mem_signals[MEM_WDATA_LSB +: DATA_W]),
    .en    (ex_mem_mem_signals[MEM_EN_BIT]),
    .write (ex_mem_mem_signals[MEM_WRITE_BIT]),
    .rdata (mem_rdata)
  );

  mem_wb_pipe_reg u_mem_wb_pipe_reg (
    .clk, .arst_n, .ex_mem_pc_next, .ex_mem_alu_out, .mem_rdata, .ex_mem_wb_signals,
    .wb_reg_write, .wb_rd, .wb_data, .wb_hlt
  );

endmodule

// ==== src/mem_wb_pipe_reg.sv ====
`timescale 1ns/1ps

module mem_wb_pipe_reg import cpu_isa_pkg::*, cpu_pipe_pkg::*; (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic [DATA_W-1:0]     ex_mem_pc_next,     // Link value for PCS
  input  logic [DATA_W-1:0]     ex_mem_alu_out,
  input  logic [DATA_W-1:0]     mem_rdata,          // Load data from the data memory
  input  logic [WB_SIG_W-1:0]   ex_mem_wb_signals,
  output logic                  wb_reg_write,       // Register file write port
  output logic [REG_ADDR_W-1:0] wb_rd,
  output logic [DATA_W-1:0]     wb_data,
  output logic                  wb_hlt              // Instruction retiring is a halt
);

  logic [DATA_W-1:0] alu_q;       // Registered ALU result
  logic [DATA_W-1:0] rdata_q;     // Registered load data
  logic [DATA_W-1:0] pc_next_q;
  logic              mem_to_reg;
  logic              pcs;

  //////////////////////////////////////////////////
  // Pipeline register
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      alu_q        <= '0;
      rdata_q      <= '0;
      pc_next_q    <= '0;
      wb_rd        <= '0;
      wb_reg_write <= 1'b0;
      mem_to_reg   <= 1'b0;
      wb_hlt       <= 1'b0;
      pcs          <= 1'b0;
    end else begin
      alu_q        <= ex_mem_alu_out;
      rdata_q      <= mem_rdata;
      pc_next_q    <= ex_mem_pc_next;
      wb_rd        <= ex_mem_wb_signals[WB_RD_LSB +: REG_ADDR_W];
      wb_reg_write <= ex_mem_wb_signals[WB_REG_WRITE_BIT];
      mem_to_reg   <= ex_mem_wb_signals[WB_MEM_TO_REG_BIT];
      wb_hlt       <= ex_mem_wb_signals[WB_HLT_BIT];
      pcs          <= ex_mem_wb_signals[WB_PCS_BIT];
    end
  end

  // PCS beats MemtoReg, the ALU result is the fallback
  assign wb_data = pcs        ? pc_next_q :
                   mem_to_reg ? rdata_q   :
                                alu_q;

  // Decode never marks one instruction as both a load and a PCS
  a_wb_sel_onehot: assert property (@(posedge clk) disable iff (!arst_n)
    !(mem_to_reg && pcs))
    else $error("MemtoReg and PCS set together");

endmodule

// ==== src/data_memory.sv ====
`timescale 1ns/1ps

module data_memory import cpu_isa_pkg::*, cpu_pipe_pkg::*; (
  input  logic                   clk,
  input  logic [DMEM_ADDR_W-1:0] addr,   // Word index
  input  logic [DATA_W-1:0]      wdata,  // Store data from the MEM bundle
  input  logic                   en,     // Access enable
  input  logic                   write,  // Store when set, load otherwise
  output logic [DATA_W-1:0]      rdata
);

  logic [DATA_W-1:0] mem [DMEM_DEPTH];  // 256 x 16 storage, contents start undefined

  // Store lands on the edge that ends the MEM cycle
  always_ff @(posedge clk) begin
    if (en && write) begin
      mem[addr] <= wdata;
    end
  end

  // Read is combinational so MEM/WB captures load data on the same edge
  assign rdata = mem[addr];

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////
  // An X address would corrupt an unknown word on a store
  a_addr_known: assert property (@(posedge clk)
    en |-> !$isunknown(addr))
    else $error("Data memory address unknown during access");

endmodule

// ==== src/ex_mem_pipe_reg.sv ====
`timescale 1ns/1ps

module ex_mem_pipe_reg import cpu_isa_pkg::*, cpu_pipe_pkg::*; (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 flush,               // Squash the instruction entering MEM
  input  logic [DATA_W-1:0]    id_ex_pc_next,
  input  logic [DATA_W-1:0]    alu_out,             // Result of the execute stage
  input  logic [MEM_SIG_W-1:0] id_ex_mem_signals,
  input  logic [WB_SIG_W-1:0]  id_ex_wb_signals,
  output logic [DATA_W-1:0]    ex_mem_pc_next,
  output logic [DATA_W-1:0]    ex_mem_alu_out,      // Also the data memory address
  output logic [MEM_SIG_W-1:0] ex_mem_mem_signals,
  output logic [WB_SIG_W-1:0]  ex_mem_wb_signals
);

  // Individual MEM fields
  logic [DATA_W-1:0]     mem_wdata;
  logic                  mem_en;
  logic                  mem_write;
  // Individual WB fields
  logic [REG_ADDR_W-1:0] rd;
  logic                  reg_write;
  logic                  mem_to_reg;
  logic                  hlt;
  logic                  pcs;

  // pc_next survives a flush, only reset clears it
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) ex_mem_pc_next <= '0;
    else         ex_mem_pc_next <= id_ex_pc_next;
  end

  //////////////////////////////////////////////////
  // Result and control fields, cleared by flush
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      {ex_mem_alu_out, mem_wdata, mem_en, mem_write} <= '0;
      {rd, reg_write, mem_to_reg, hlt, pcs}          <= '0;
    end else if (flush) begin
      {ex_mem_alu_out, mem_wdata, mem_en, mem_write} <= '0;  // Becomes a bubble
      {rd, reg_write, mem_to_reg, hlt, pcs}          <= '0;
    end else begin
      ex_mem_alu_out <= alu_out;
      mem_wdata      <= id_ex_mem_signals[MEM_WDATA_LSB +: DATA_W];
      mem_en         <= id_ex_mem_signals[MEM_EN_BIT];
      mem_write      <= id_ex_mem_signals[MEM_WRITE_BIT];
      rd             <= id_ex_wb_signals[WB_RD_LSB +: REG_ADDR_W];
      reg_write      <= id_ex_wb_signals[WB_REG_WRITE_BIT];
      mem_to_reg     <= id_ex_wb_signals[WB_MEM_TO_REG_BIT];
      hlt            <= id_ex_wb_signals[WB_HLT_BIT];
      pcs            <= id_ex_wb_signals[WB_PCS_BIT];
    end
  end

  // Repack in the same bit order as the incoming bundles
  assign ex_mem_mem_signals = {mem_wdata, mem_en, mem_write};
  assign ex_mem_wb_signals  = {rd, reg_write, mem_to_reg, hlt, pcs};

  // The bundles handed to MEM carry no access and no register write after a flush
  a_flush_kills: assert property (@(posedge clk) disable iff (!arst_n)
    flush |=> (!ex_mem_mem_signals[MEM_EN_BIT] && !ex_mem_wb_signals[WB_REG_WRITE_BIT]))
    else $error("Flushed instruction still active in MEM");

endmodule

// ==== src/alu.sv ====
`timescale 1ns/1ps

module alu import cpu_isa_pkg::*; (
  input  logic              clk,        // Only samples the opcode check
  input  logic              arst_n,
  input  alu_op_e           alu_op,     // Decoded operation
  input  logic [DATA_W-1:0] operand_a,  // rs after forwarding
  input  logic [DATA_W-1:0] operand_b,  // rt after forwarding, or imm
  output logic [DATA_W-1:0] alu_out
);

  logic [DATA_W-1:0]   sum;       // Raw two's complement sum
  logic [DATA_W-1:0]   diff;      // Raw two's complement difference
  logic                add_ovf;   // Signed overflow on add
  logic                sub_ovf;   // Signed overflow on subtract
  logic [DATA_W-1:0]   sat_val;   // Limit in the direction of operand a
  logic [SHAMT_W-1:0]  shamt;
  logic [2*DATA_W-1:0] ror_wide;  // Doubled word so a right shift rotates

  assign shamt = operand_b[SHAMT_W-1:0];
  assign sum   = operand_a + operand_b;
  assign diff  = operand_a - operand_b;

  // Add overflows when both signs agree and the result sign differs
  assign add_ovf = (operand_a[DATA_W-1] == operand_b[DATA_W-1]) &&
                   (sum[DATA_W-1] != operand_a[DATA_W-1]);
  // Subtract overflows when the signs differ and the result takes b's sign
  assign sub_ovf = (operand_a[DATA_W-1] != operand_b[DATA_W-1]) &&
                   (diff[DATA_W-1] != operand_a[DATA_W-1]);

  // On overflow the true result always lies past the limit on a's side
  assign sat_val = operand_a[DATA_W-1] ? SAT_NEG : SAT_POS;

  assign ror_wide = {operand_a, operand_a} >> shamt;

  //////////////////////////////////////////////////
  // Result select
  //////////////////////////////////////////////////
  always_comb begin
    case (alu_op)
      ALU_ADD: alu_out = add_ovf ? sat_val : sum;
      ALU_SUB: alu_out = sub_ovf ? sat_val : diff;
      ALU_XOR: alu_out = operand_a ^ operand_b;
      ALU_SLL: alu_out = operand_a << shamt;
      ALU_SRA: alu_out = $signed(operand_a) >>> shamt;      // Sign bit fills from the left
      ALU_ROR: alu_out = ror_wide[DATA_W-1:0];              // Low half holds the rotated word
      ALU_LLB: alu_out = {operand_a[DATA_W-1:BYTE_W], operand_b[BYTE_W-1:0]};
      ALU_LHB: alu_out = {operand_b[BYTE_W-1:0], operand_a[BYTE_W-1:0]};
      default: alu_out = '0;                                // Unreachable with a 3 bit enum
    endcase
  end

  // Decode must always present a defined opcode once out of reset
  a_op_known: assert property (@(posedge clk) disable iff (!arst_n)
    !$isunknown(alu_op))
    else $error("ALU opcode is unknown");

endmodule

// ==== src/operand_forward.sv ====
`timescale 1ns/1ps

module operand_forward import cpu_isa_pkg::*; (
  input  logic [REG_ADDR_W-1:0] rs_addr,           // Source register of operand a
  input  logic [REG_ADDR_W-1:0] rt_addr,           // Source register of operand b
  input  logic [DATA_W-1:0]     rs_data,           // Register file value for rs
  input  logic [DATA_W-1:0]     rt_data,           // Register file value for rt
  input  logic [DATA_W-1:0]     imm,               // Sign extended immediate from decode
  input  logic                  alu_src,           // Operand b takes imm when set
  input  logic [DATA_W-1:0]     ex_mem_alu_out,    // Result one instruction ahead
  input  logic [REG_ADDR_W-1:0] ex_mem_rd,
  input  logic                  ex_mem_reg_write,
  input  logic [REG_ADDR_W-1:0] wb_rd,             // Result two instructions ahead
  input  logic                  wb_reg_write,
  input  logic [DATA_W-1:0]     wb_data,
  output logic [DATA_W-1:0]     operand_a,
  output logic [DATA_W-1:0]     operand_b
);

  logic [DATA_W-1:0] fwd_b;  // Forwarded rt value before the immediate mux

  // Register 0 is hardwired, so a write to it must never be forwarded
  function automatic logic [DATA_W-1:0] pick(input logic [REG_ADDR_W-1:0] src,
                                             input logic [DATA_W-1:0]     reg_val);
    logic [DATA_W-1:0] val;
    val = reg_val;                                   // Default is the register file read
    if (wb_reg_write && (wb_rd != '0) && (wb_rd == src))
      val = wb_data;                                 // Older result from MEM/WB
    if (ex_mem_reg_write && (ex_mem_rd != '0) && (ex_mem_rd == src))
      val = ex_mem_alu_out;                          // Youngest result wins
    return val;
  endfunction

  always_comb begin
    operand_a = pick(rs_addr, rs_data);
    fwd_b     = pick(rt_addr, rt_data);
  end

  // The immediate bypasses forwarding altogether
  assign operand_b = alu_src ? imm : fwd_b;

endmodule

// ==== src/cpu_pipe_pkg.sv ====
package cpu_pipe_pkg;

  import cpu_isa_pkg::*;  // Store data and rd widths follow the ISA

  //////////////////////////////////////////////////
  // MEM control bundle {wdata, en, write}
  //////////////////////////////////////////////////
  localparam int MEM_WRITE_BIT = 0;                        // Store when set together with en
  localparam int MEM_EN_BIT    = 1;                        // Memory access in this instruction
  localparam int MEM_WDATA_LSB = 2;                        // Store data sits above the two flags
  localparam int MEM_SIG_W     = MEM_WDATA_LSB + DATA_W;   // 18 bits in total

  //////////////////////////////////////////////////
  // WB control bundle {rd, reg_write, mem_to_reg, hlt, pcs}
  //////////////////////////////////////////////////
  localparam int WB_PCS_BIT        = 0;  // Write back pc_next instead of a result
  localparam int WB_HLT_BIT        = 1;  // Halt once this instruction retires
  localparam int WB_MEM_TO_REG_BIT = 2;  // Write back the memory read data
  localparam int WB_REG_WRITE_BIT  = 3;  // Register file write enable
  localparam int WB_RD_LSB         = 4;  // Destination register number
  localparam int WB_SIG_W          = WB_RD_LSB + REG_ADDR_W;  // 8 bits in total

  // Data memory is word addressed, the byte offset bit is dropped
  localparam int DMEM_ADDR_W   = 8;
  localparam int DMEM_ADDR_LSB = 1;                 // ALU result bits 8:1 form the index
  localparam int DMEM_DEPTH    = 1 << DMEM_ADDR_W;  // 256 words

endpackage

// ==== src/cpu_isa_pkg.sv ====
package cpu_isa_pkg;

  //////////////////////////////////////////////////
  // Datapath and register file geometry
  //////////////////////////////////////////////////
  localparam int DATA_W     = 16;  // Width of every register and ALU operand
  localparam int REG_ADDR_W = 4;   // Sixteen architectural registers
  localparam int BYTE_W     = 8;   // Byte loads move half a word
  localparam int SHAMT_W    = 4;   // Shift amount comes from operand b bits 3:0

  // Saturation limits for signed add and subtract
  localparam logic [DATA_W-1:0] SAT_POS = 16'h7FFF;
  localparam logic [DATA_W-1:0] SAT_NEG = 16'h8000;

  //////////////////////////////////////////////////
  // ALU opcodes as decoded in ID
  //////////////////////////////////////////////////
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,  // Signed add, saturating
    ALU_SUB = 3'd1,  // Signed subtract, saturating
    ALU_XOR = 3'd2,
    ALU_SLL = 3'd3,  // Logical shift left
    ALU_SRA = 3'd4,  // Arithmetic shift right, sign fills from the top
    ALU_ROR = 3'd5,  // Rotate right
    ALU_LLB = 3'd6,  // Keep the high byte of a, load the low byte from b
    ALU_LHB = 3'd7   // Load the high byte from b, keep the low byte of a
  } alu_op_e;

endpackage
